//--- common/uart_pkg.sv
package uart_pkg;

  localparam int CMD_WIDTH = 16;
  localparam int DATA_BITS = 8;
  localparam int RW_BIT    = 15;

  // idle line between the two frames of a write, in bit times
  localparam int GAP_BITS  = 2;

  typedef logic [DATA_BITS-1:0] byte_t;

  typedef enum logic [2:0]
  {
    IDLE,
    START,
    DATA,
    PARITY,
    STOP
  } frame_state_e;

  function automatic logic cmd_is_write(input logic [CMD_WIDTH-1:0] cmd);
    return cmd[RW_BIT];
  endfunction

  function automatic byte_t cmd_hi_byte(input logic [CMD_WIDTH-1:0] cmd);
    return cmd[CMD_WIDTH-1 -: DATA_BITS];
  endfunction

  function automatic byte_t cmd_lo_byte(input logic [CMD_WIDTH-1:0] cmd);
    return cmd[DATA_BITS-1:0];
  endfunction

  // bit that makes the total count of ones even
  function automatic logic even_parity(input byte_t data);
    return ^data;
  endfunction

endpackage

//--- design/uart_core/uart_tx.sv
module uart_tx
  import uart_pkg::*;
#(
  parameter int CLKS_PER_BIT = 434
)
(
  input  logic  clk,
  input  logic  rst_n,
  input  logic  tx_start,
  input  byte_t tx_byte,
  output logic  tx_busy,
  output logic  tx
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
  localparam int IDX_W = $clog2(DATA_BITS);
  localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(CLKS_PER_BIT - 1);
  localparam logic [IDX_W-1:0] IDX_LAST = IDX_W'(DATA_BITS - 1);

  frame_state_e     state;
  logic [CNT_W-1:0] bit_cnt;
  logic [IDX_W-1:0] bit_idx;
  byte_t            shift_q;
  logic             parity_q;
  logic             bit_end;

  assign bit_end = (bit_cnt == BIT_LAST);
  assign tx_busy = (state != IDLE);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state   <= IDLE;
      bit_cnt <= '0;
      bit_idx <= '0;
    end
    else
    begin
      if (state == IDLE || bit_end)
        bit_cnt <= '0;
      else
        bit_cnt <= bit_cnt + 1'b1;

      case (state)
        IDLE:
        begin
          if (tx_start)
            state <= START;
        end
        START:
        begin
          if (bit_end)
          begin
            state   <= DATA;
            bit_idx <= '0;
          end
        end
        DATA:
        begin
          if (bit_end)
          begin
            if (bit_idx == IDX_LAST)
              state <= PARITY;
            else
              bit_idx <= bit_idx + 1'b1;
          end
        end
        PARITY:
        begin
          if (bit_end)
            state <= STOP;
        end
        STOP:
        begin
          if (bit_end)
            state <= IDLE;
        end
        default:
          state <= IDLE;
      endcase
    end
  end

  // byte is taken only while idle
  always_ff @(posedge clk)
  begin
    if (state == IDLE && tx_start)
    begin
      shift_q  <= tx_byte;
      parity_q <= even_parity(tx_byte);
    end
    else if (state == DATA && bit_end)
      shift_q <= shift_q >> 1;
  end

  always_comb
  begin
    case (state)
      START:   tx = 1'b0;
      DATA:    tx = shift_q[0];
      PARITY:  tx = parity_q;
      default: tx = 1'b1;
    endcase
  end

endmodule

//--- design/uart_core/uart_rx.sv
module uart_rx
  import uart_pkg::*;
#(
  parameter int CLKS_PER_BIT = 434
)
(
  input  logic  clk,
  input  logic  rst_n,
  input  logic  rx,
  output logic  rx_done,
  output byte_t rx_byte,
  output logic  rx_err
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
  localparam int IDX_W = $clog2(DATA_BITS);
  localparam logic [CNT_W-1:0] BIT_LAST  = CNT_W'(CLKS_PER_BIT - 1);
  localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(CLKS_PER_BIT / 2 - 1);
  localparam logic [IDX_W-1:0] IDX_LAST  = IDX_W'(DATA_BITS - 1);

  frame_state_e     state;
  logic [CNT_W-1:0] bit_cnt;
  logic [IDX_W-1:0] bit_idx;
  logic             rx_meta;
  logic             rx_sync;
  logic             rx_last;
  logic             fall;
  logic             bit_end;
  logic             half_end;
  byte_t            shift_q;
  logic             parity_bad_q;

  // two-flop synchronizer plus one stage for edge detect
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_last <= 1'b1;
    end
    else
    begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_last <= rx_sync;
    end
  end

  assign fall     = rx_last & ~rx_sync;
  assign bit_end  = (bit_cnt == BIT_LAST);
  assign half_end = (bit_cnt == HALF_LAST);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state   <= IDLE;
      bit_cnt <= '0;
      bit_idx <= '0;
      rx_done <= 1'b0;
    end
    else
    begin
      rx_done <= 1'b0;
      bit_cnt <= bit_cnt + 1'b1;
      case (state)
        IDLE:
        begin
          bit_cnt <= '0;
          if (fall)
            state <= START;
        end
        START:
        begin
          // still low at mid-bit, otherwise a glitch
          if (half_end)
          begin
            bit_cnt <= '0;
            bit_idx <= '0;
            state   <= rx_sync ? IDLE : DATA;
          end
        end
        DATA:
        begin
          if (bit_end)
          begin
            bit_cnt <= '0;
            if (bit_idx == IDX_LAST)
              state <= PARITY;
            else
              bit_idx <= bit_idx + 1'b1;
          end
        end
        PARITY:
        begin
          if (bit_end)
          begin
            bit_cnt <= '0;
            state   <= STOP;
          end
        end
        STOP:
        begin
          // back to idle at mid stop bit, line is high by now
          if (bit_end)
          begin
            rx_done <= 1'b1;
            state   <= IDLE;
          end
        end
        default:
          state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (state == DATA && bit_end)
      shift_q <= {rx_sync, shift_q[DATA_BITS-1:1]};
    if (state == PARITY && bit_end)
      parity_bad_q <= rx_sync ^ even_parity(shift_q);
    if (state == STOP && bit_end)
    begin
      rx_byte <= shift_q;
      rx_err  <= parity_bad_q | ~rx_sync;
    end
  end

endmodule

//--- design/uart_cmd_ctrl.sv
module uart_cmd_ctrl
  import uart_pkg::*;
#(
  parameter int CLKS_PER_BIT = 434
)
(
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [CMD_WIDTH-1:0] cmd_in,
  input  logic                 cmd_vld,
  output logic                 cmd_rdy,
  output logic                 tx_start,
  output byte_t                tx_byte,
  input  logic                 tx_busy,
  input  logic                 rx_done,
  input  byte_t                rx_byte,
  input  logic                 rx_err,
  output logic                 read_rdy,
  output byte_t                read_data,
  output logic                 read_err
);

  localparam int GAP_CYCLES = GAP_BITS * CLKS_PER_BIT;
  localparam int GAP_W      = $clog2(GAP_CYCLES + 1);

  // line is idle from the cycle busy drops up to and including the
  // tx_start cycle, hence three cycles less of counting
  localparam logic [GAP_W-1:0] GAP_LAST = GAP_W'(GAP_CYCLES - 3);

  typedef enum logic [2:0]
  {
    C_IDLE,
    C_HI_START,
    C_HI_BUSY,
    C_GAP,
    C_LO_START,
    C_LO_BUSY,
    C_RESP
  } ctrl_state_e;

  ctrl_state_e          state;
  logic [GAP_W-1:0]     gap_cnt;
  logic [CMD_WIDTH-1:0] cmd_q;
  logic                 cmd_accept;
  logic                 gap_end;

  assign cmd_accept = cmd_vld & cmd_rdy;
  assign gap_end    = (state == C_GAP) && (gap_cnt == GAP_LAST);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= C_IDLE;
      gap_cnt  <= '0;
      cmd_rdy  <= 1'b1;
      tx_start <= 1'b0;
      read_rdy <= 1'b0;
    end
    else
    begin
      tx_start <= 1'b0;
      read_rdy <= 1'b0;
      case (state)
        C_IDLE:
        begin
          if (cmd_accept)
          begin
            cmd_rdy  <= 1'b0;
            tx_start <= 1'b1;
            state    <= C_HI_START;
          end
        end
        // busy shows up one cycle after tx_start
        C_HI_START:
          state <= C_HI_BUSY;
        C_HI_BUSY:
        begin
          if (!tx_busy)
          begin
            gap_cnt <= '0;
            state   <= cmd_is_write(cmd_q) ? C_GAP : C_RESP;
          end
        end
        C_GAP:
        begin
          if (gap_end)
          begin
            tx_start <= 1'b1;
            state    <= C_LO_START;
          end
          else
            gap_cnt <= gap_cnt + 1'b1;
        end
        C_LO_START:
          state <= C_LO_BUSY;
        C_LO_BUSY:
        begin
          if (!tx_busy)
          begin
            cmd_rdy <= 1'b1;
            state   <= C_IDLE;
          end
        end
        // no timeout here
        C_RESP:
        begin
          if (rx_done)
          begin
            read_rdy <= 1'b1;
            cmd_rdy  <= 1'b1;
            state    <= C_IDLE;
          end
        end
        default:
          state <= C_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (cmd_accept)
    begin
      cmd_q   <= cmd_in;
      tx_byte <= cmd_hi_byte(cmd_in);
    end
    else if (gap_end)
      tx_byte <= cmd_lo_byte(cmd_q);

    if (state == C_RESP && rx_done)
    begin
      read_data <= rx_byte;
      read_err  <= rx_err;
    end
  end

endmodule

//--- design/uart_bridge.sv
module uart_bridge
  import uart_pkg::*;
#(
  parameter int CLKS_PER_BIT = 434
)
(
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [CMD_WIDTH-1:0] cmd_in,
  input  logic                 cmd_vld,
  output logic                 cmd_rdy,
  input  logic                 rx,
  output logic                 tx,
  output logic                 read_rdy,
  output byte_t                read_data,
  output logic                 read_err
);

  logic  tx_start;
  byte_t tx_byte;
  logic  tx_busy;
  logic  rx_done;
  byte_t rx_byte;
  logic  rx_err;

  uart_cmd_ctrl #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) uart_cmd_ctrl_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .tx_start  (tx_start),
    .tx_byte   (tx_byte),
    .tx_busy   (tx_busy),
    .rx_done   (rx_done),
    .rx_byte   (rx_byte),
    .rx_err    (rx_err),
    .read_rdy  (read_rdy),
    .read_data (read_data),
    .read_err  (read_err)
  );

  uart_tx #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) uart_tx_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx_busy  (tx_busy),
    .tx       (tx)
  );

  // receiver runs continuously, sequencer filters
  uart_rx #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) uart_rx_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .rx      (rx),
    .rx_done (rx_done),
    .rx_byte (rx_byte),
    .rx_err  (rx_err)
  );

endmodule

//--- sim/uart_bridge_tb.sv
module uart_bridge_tb
  import uart_pkg::*;
();

  localparam int CLKS_PER_BIT   = 8;
  localparam int NUM_ENTRIES    = 8;
  localparam int FRAME_CYCLES   = 11 * CLKS_PER_BIT;
  localparam int MIN_GAP_CYCLES = GAP_BITS * CLKS_PER_BIT;
  localparam int TIMEOUT_CYCLES = NUM_ENTRIES * (3 * 11 + GAP_BITS + 20) * CLKS_PER_BIT * 2;
  localparam int RNG_SEED       = 1;

  logic                 clk;
  logic                 rst_n;
  logic [CMD_WIDTH-1:0] cmd_in;
  logic                 cmd_vld;
  logic                 cmd_rdy;
  logic                 rx;
  logic                 tx;
  logic                 read_rdy;
  byte_t                read_data;
  logic                 read_err;

  // stimulus table of command, read response byte and parity corruption flag
  logic [CMD_WIDTH-1:0] tbl_cmd     [NUM_ENTRIES];
  byte_t                tbl_resp    [NUM_ENTRIES];
  logic                 tbl_corrupt [NUM_ENTRIES];

  // frames the line model should see on tx in order
  byte_t exp_byte_q   [$];
  bit    exp_read_q   [$];
  bit    exp_second_q [$];

  // read responses held until their frame is decoded
  byte_t resp_byte_q [$];
  bit    resp_bad_q  [$];

  int error_count   = 0;
  int check_count   = 0;
  int frames_seen   = 0;
  int reads_decoded = 0;
  int cycle_count   = 0;

  uart_bridge #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) uart_bridge_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .rx        (rx),
    .tx        (tx),
    .read_rdy  (read_rdy),
    .read_data (read_data),
    .read_err  (read_err)
  );

  initial
    clk = 1'b0;

  always #5 clk = ~clk;

  always @(posedge clk)
    cycle_count <= cycle_count + 1;

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    check_count++;
    if (actual !== expected)
    begin
      error_count++;
      $display("ERROR at %0t: %s expected 0x%0h, got 0x%0h", $time, name, expected, actual);
    end
  endtask

  task automatic flag_failure(input string what);
    error_count++;
    $display("at %0t: %s", $time, what);
  endtask

  // reference parity by counting ones
  function automatic logic parity_of(input byte_t value);
    int ones;
    int k;
    ones = 0;
    for (k = 0; k < DATA_BITS; k++)
      ones += value[k];
    return (ones % 2) == 1;
  endfunction

  task automatic set_entry(input int idx, input logic [CMD_WIDTH-1:0] cmd,
                           input byte_t resp, input logic corrupt);
    tbl_cmd[idx]     = cmd;
    tbl_resp[idx]    = resp;
    tbl_corrupt[idx] = corrupt;
  endtask

  task automatic load_table();
    // bit 15 set means write
    set_entry(0, 16'h9A3C, 8'h00, 1'b0);
    set_entry(1, 16'h1200, 8'h5E, 1'b0);
    set_entry(2, 16'hFF00, 8'h00, 1'b0);
    set_entry(3, 16'h7F11, 8'hA7, 1'b1);
    set_entry(4, 16'h0042, 8'h00, 1'b0);
    set_entry(5, 16'h8001, 8'h00, 1'b0);
    set_entry(6, 16'h3355, 8'hFF, 1'b1);
    set_entry(7, 16'hC3E7, 8'h00, 1'b0);
  endtask

  task automatic drive_rx_bit(input logic value);
    rx <= value;
    repeat (CLKS_PER_BIT) @(posedge clk);
  endtask

  task automatic check_read_result(input int idx);
    check_value("read_data", tbl_resp[idx], read_data);
    check_value("read_err", tbl_corrupt[idx], read_err);
  endtask

  // host drives reset, idle check and back-to-back commands from the table
  initial
  begin : host
    int   i;
    int   frames_expected;
    int   read_pulses;
    int   idle_low;
    logic is_read;
    rst_n   = 1'b0;
    cmd_vld = 1'b0;
    cmd_in  = '0;
    frames_expected = 0;
    load_table();

    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    @(posedge clk);
    check_value("tx", 1, tx);
    check_value("cmd_rdy", 1, cmd_rdy);
    check_value("read_rdy", 0, read_rdy);

    // line must stay quiet with no command
    idle_low = 0;
    repeat (4 * CLKS_PER_BIT)
    begin
      @(posedge clk);
      if (tx !== 1'b1)
        idle_low++;
    end
    check_value("tx low cycles while idle", 0, idle_low);
    check_value("read_rdy", 0, read_rdy);

    cmd_in  <= tbl_cmd[0];
    cmd_vld <= 1'b1;
    @(posedge clk);
    while (!cmd_rdy)
      @(posedge clk);

    for (i = 0; i < NUM_ENTRIES; i++)
    begin
      // this edge transfers entry i
      is_read = !tbl_cmd[i][RW_BIT];
      exp_byte_q.push_back(tbl_cmd[i][CMD_WIDTH-1 -: 8]);
      exp_read_q.push_back(is_read);
      exp_second_q.push_back(1'b0);
      if (is_read)
      begin
        resp_byte_q.push_back(tbl_resp[i]);
        resp_bad_q.push_back(tbl_corrupt[i]);
        frames_expected += 1;
      end
      else
      begin
        exp_byte_q.push_back(tbl_cmd[i][7:0]);
        exp_read_q.push_back(1'b0);
        exp_second_q.push_back(1'b1);
        frames_expected += 2;
      end

      if (i + 1 < NUM_ENTRIES)
        cmd_in <= tbl_cmd[i+1];
      else
        cmd_vld <= 1'b0;

      read_pulses = 0;
      @(posedge clk);
      while (!cmd_rdy)
      begin
        if (read_rdy)
        begin
          read_pulses++;
          check_read_result(i);
        end
        @(posedge clk);
      end

      // read_rdy comes with cmd_rdy
      if (read_rdy)
      begin
        read_pulses++;
        check_read_result(i);
      end
      check_value("read_rdy pulses", is_read ? 1 : 0, read_pulses);
      check_value("frames decoded", frames_expected, frames_seen);
    end

    // long enough for a stray frame to be fully decoded
    repeat (FRAME_CYCLES + 2 * CLKS_PER_BIT) @(posedge clk);
    check_value("frames decoded", frames_expected, frames_seen);
    check_value("frames still expected", 0, exp_byte_q.size());
    check_value("responses not sent", 0, resp_byte_q.size());

    $display("checks run: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

  // line model decoding every frame on tx at bit centers
  initial
  begin : tx_monitor
    byte_t data;
    logic  par_bit;
    logic  stop_bit;
    int    start_cyc;
    int    last_end_cyc;
    int    j;
    byte_t want;
    bit    want_read;
    bit    want_second;
    last_end_cyc = 0;
    wait (rst_n === 1'b1);
    forever
    begin
      @(posedge clk);
      if (tx === 1'b0)
      begin
        // first low sample is one cycle into the start bit
        start_cyc = cycle_count - 1;
        repeat (CLKS_PER_BIT / 2 - 1) @(posedge clk);
        if (tx !== 1'b0)
          flag_failure("start bit on tx went high again before mid-bit");
        else
        begin
          data = '0;
          for (j = 0; j < DATA_BITS; j++)
          begin
            repeat (CLKS_PER_BIT) @(posedge clk);
            data[j] = tx;
          end
          repeat (CLKS_PER_BIT) @(posedge clk);
          par_bit = tx;
          repeat (CLKS_PER_BIT) @(posedge clk);
          stop_bit = tx;
          frames_seen++;

          if (stop_bit !== 1'b1)
            flag_failure($sformatf("framing error on tx, stop bit low for byte 0x%0h", data));
          check_value("tx parity", parity_of(data), par_bit);

          if (exp_byte_q.size() == 0)
            flag_failure($sformatf("unexpected frame on tx carrying 0x%0h", data));
          else
          begin
            want        = exp_byte_q.pop_front();
            want_read   = exp_read_q.pop_front();
            want_second = exp_second_q.pop_front();
            check_value("tx byte", want, data);
            if (want_second && (start_cyc - last_end_cyc < MIN_GAP_CYCLES))
              flag_failure($sformatf("gap between write frames is %0d cycles, need %0d",
                                     start_cyc - last_end_cyc, MIN_GAP_CYCLES));
            if (want_read)
              reads_decoded++;
          end
          last_end_cyc = start_cyc + FRAME_CYCLES;
        end
      end
    end
  end

  // answers each decoded read frame after a random idle
  initial
  begin : rx_responder
    byte_t       resp;
    bit          bad;
    int          idle_bits;
    int          sent;
    int          j;
    int          rng_state;
    int unsigned seed_ret;
    rx        = 1'b1;
    sent      = 0;
    rng_state = RNG_SEED;
    seed_ret  = $urandom(rng_state);
    forever
    begin
      @(negedge clk);
      if (reads_decoded > sent && resp_byte_q.size() != 0)
      begin
        resp = resp_byte_q.pop_front();
        bad  = resp_bad_q.pop_front();
        sent++;
        idle_bits = $urandom % 21;
        @(posedge clk);
        repeat (idle_bits * CLKS_PER_BIT) @(posedge clk);
        drive_rx_bit(1'b0);
        for (j = 0; j < DATA_BITS; j++)
          drive_rx_bit(resp[j]);
        drive_rx_bit(parity_of(resp) ^ bad);
        drive_rx_bit(1'b1);
      end
    end
  end

  initial
  begin : watchdog
    wait (cycle_count >= TIMEOUT_CYCLES);
    flag_failure($sformatf("run timed out after %0d cycles, a command never finished",
                           TIMEOUT_CYCLES));
    $display("checks run: %0d, errors: %0d", check_count, error_count);
    $display("Test failures found");
    $finish;
  end

endmodule

//--- vlog.f
common/uart_pkg.sv
design/uart_core/uart_tx.sv
design/uart_core/uart_rx.sv
design/uart_cmd_ctrl.sv
design/uart_bridge.sv
sim/uart_bridge_tb.sv

//--- Bender.yml
package:
  name: uart_bridge

sources:
  - files:
      - common/uart_pkg.sv
      - design/uart_core/uart_tx.sv
      - design/uart_core/uart_rx.sv
      - design/uart_cmd_ctrl.sv
      - design/uart_bridge.sv
  - target: simulation
    files:
      - sim/uart_bridge_tb.sv
